/* list.f */
+incdir+.
sa_pkg.sv
sa_core_if.sv
shift_reg.sv
sys_array_pe.sv
sys_array_basic.sv
sys_array_fetcher.sv
sys_array_top.sv
tb_sys_array.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -f list.f --top-module tb_sys_array -o tb_sys_array \
    && ./obj_dir/tb_sys_array | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

/* sa_core_if.sv */
`timescale 1ns/1ps
`include "sa_settings.svh"

interface sa_core_if import sa_pkg::*; ();

    logic  weights_load;                               // Already gated while busy
    elem_t [0:`SA_W_ROWS-1][0:`SA_W_COLS-1] weights;   // W[i][k]
    elem_t [0:`SA_A_ROWS-1] a_lanes;                   // Skewed activations, zero when idle
    acc_t  [0:`SA_W_ROWS-1] p_lanes;                   // Bottom sums, one per result row

    // Sequencer side
    modport fetch (output weights_load, output weights, output a_lanes, input p_lanes);

    // PE grid side
    modport array (input weights_load, input weights, input a_lanes, output p_lanes);

endinterface

/* sa_pkg.sv */
`include "sa_settings.svh"

package sa_pkg;

    typedef logic [`SA_DATA_WIDTH-1:0]   elem_t;  // One matrix element
    typedef logic [2*`SA_DATA_WIDTH-1:0] acc_t;   // One sum, wraps mod 2^16

    // Shift register control codes
    typedef enum logic [1:0] {
        SR_HOLD      = 2'b00,
        SR_LOAD      = 2'b01,  // Parallel load
        SR_SHIFT_IN  = 2'b10,  // New word at the tail
        SR_SHIFT_OUT = 2'b11   // Head on data_read, chain advances
    } sr_mode_t;

    typedef enum logic [1:0] {
        FETCH_IDLE = 2'b00,
        FETCH_RUN  = 2'b01,
        FETCH_DONE = 2'b10   // Result held, ready high
    } fetch_state_t;

endpackage

/* sa_settings.svh */
`ifndef SA_SETTINGS_SVH
`define SA_SETTINGS_SVH

// Element width in bits
`define SA_DATA_WIDTH 8

// Weight matrix, its column count is the inner dimension
`define SA_W_ROWS 3
`define SA_W_COLS 4

// Data matrix, row count equals SA_W_COLS
`define SA_A_ROWS 4
`define SA_A_COLS 3

`endif

/* shift_reg.sv */
`timescale 1ns/1ps

module shift_reg
    import sa_pkg::*;
#(
    parameter int WIDTH  = 8,
    parameter int LENGTH = 3
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  sr_mode_t                     ctrl_code,
    input  logic [0:LENGTH-1][WIDTH-1:0] data_in,     // Parallel load
    input  logic [WIDTH-1:0]             data_write,  // Serial in at the tail
    output logic [WIDTH-1:0]             data_read,   // Serial out from the head
    output logic [0:LENGTH-1][WIDTH-1:0] data_out     // Parallel read
);

    // Index 0 is the head
    logic [0:LENGTH-1][WIDTH-1:0] chain;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            chain <= '0;
        end else begin
            case (ctrl_code)
                SR_LOAD: chain <= data_in;
                SR_SHIFT_OUT, SR_SHIFT_IN: begin
                    for (int n = 0; n < LENGTH - 1; n++) begin
                        chain[n] <= chain[n+1];
                    end
                    // Zeros fill behind a word that leaves, so an emptied chain reads zero
                    chain[LENGTH-1] <= (ctrl_code == SR_SHIFT_IN) ? data_write : '0;
                end
                default: chain <= chain;
            endcase
        end
    end

    // Head is visible only during its shift-out cycle
    assign data_read = (ctrl_code == SR_SHIFT_OUT) ? chain[0] : '0;
    assign data_out  = chain;

endmodule

/* sys_array_basic.sv */
`timescale 1ns/1ps
`include "sa_settings.svh"

module sys_array_basic
    import sa_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    sa_core_if.array  core
);

    // act[k][i] enters PE (k,i) from the left, last column is the right edge
    elem_t act  [`SA_A_ROWS][`SA_W_ROWS+1];
    // psum[k][i] enters PE (k,i) from above, last row is the bottom edge
    acc_t  psum [`SA_A_ROWS+1][`SA_W_ROWS];

    genvar k, i;

    generate
        for (k = 0; k < `SA_A_ROWS; k++) begin : g_left
            assign act[k][0] = core.a_lanes[k];
        end

        for (i = 0; i < `SA_W_ROWS; i++) begin : g_cols
            assign psum[0][i]      = '0;              // Top row starts from zero
            assign core.p_lanes[i] = psum[`SA_A_ROWS][i];
        end

        // Row k carries inner index k, column i produces result row i
        for (k = 0; k < `SA_A_ROWS; k++) begin : g_row
            for (i = 0; i < `SA_W_ROWS; i++) begin : g_col
                sys_array_pe pe (
                    .clk         (clk),
                    .reset_n     (reset_n),
                    .weight_load (core.weights_load),
                    .weight_in   (core.weights[i][k]),  // PE (k,i) holds W[i][k]
                    .act_in      (act[k][i]),
                    .sum_in      (psum[k][i]),
                    .act_out     (act[k][i+1]),
                    .sum_out     (psum[k+1][i])
                );
            end
        end
    endgenerate

endmodule

/* sys_array_fetcher.sv */
`timescale 1ns/1ps
`include "sa_settings.svh"

module sys_array_fetcher
    import sa_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      load_params,
    input  logic      start_comp,
    input  elem_t     [0:`SA_W_ROWS-1][0:`SA_W_COLS-1] input_data_w,
    input  elem_t     [0:`SA_A_ROWS-1][0:`SA_A_COLS-1] input_data_b,
    output logic      ready,
    output acc_t      [0:`SA_W_ROWS-1][0:`SA_A_COLS-1] out_data,
    sa_core_if.fetch  core
);

    // Cycles from the first shift slot to the result latch
    localparam int FETCH_LENGTH = `SA_A_COLS + `SA_A_ROWS + `SA_W_ROWS + 1;
    localparam int CNT_W        = $clog2(FETCH_LENGTH);

    fetch_state_t     state;
    logic [CNT_W-1:0] cnt;     // Shift slot while running
    logic             busy;
    logic             accept;  // Start taken this cycle

    sr_mode_t rd_mode [`SA_A_ROWS];
    sr_mode_t wr_mode [`SA_W_ROWS];

    elem_t [0:`SA_A_ROWS-1]                 lane_data;
    acc_t  [0:`SA_W_ROWS-1][0:`SA_A_COLS-1] result_w;   // Write register contents

    assign busy   = (state == FETCH_RUN);
    assign accept = start_comp && !busy;

    // Weights go straight to the PEs, but not during a run
    assign core.weights_load = load_params && !busy;
    assign core.weights      = input_data_w;
    assign core.a_lanes      = lane_data;

    // Skew schedule
    always_comb begin
        for (int k = 0; k < `SA_A_ROWS; k++) begin
            rd_mode[k] = SR_HOLD;
            if (accept)
                rd_mode[k] = SR_LOAD;
            else if (busy && cnt >= k && cnt < k + `SA_A_COLS)
                rd_mode[k] = SR_SHIFT_OUT;  // Lane k starts k slots late
        end
        for (int i = 0; i < `SA_W_ROWS; i++) begin
            // C[i][j] reaches the bottom of column i at slot j+i+A_ROWS
            if (busy && cnt >= i + `SA_A_ROWS && cnt < i + `SA_A_ROWS + `SA_A_COLS)
                wr_mode[i] = SR_SHIFT_IN;
            else
                wr_mode[i] = SR_HOLD;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= FETCH_IDLE;
            cnt      <= '0;
            ready    <= 1'b0;
            out_data <= '0;
        end else begin
            case (state)
                FETCH_IDLE, FETCH_DONE: begin
                    if (start_comp) begin
                        state <= FETCH_RUN;
                        cnt   <= '0;
                        ready <= 1'b0;
                    end
                end
                FETCH_RUN: begin
                    if (cnt == FETCH_LENGTH - 1) begin
                        state    <= FETCH_DONE;
                        cnt      <= '0;
                        out_data <= result_w;  // Held until the next start
                        ready    <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    genvar k, i;

    generate
        // One read register per inner-dimension lane, holding row k of B
        for (k = 0; k < `SA_A_ROWS; k++) begin : g_rd
            shift_reg #(
                .WIDTH  ($bits(elem_t)),
                .LENGTH (`SA_A_COLS)
            ) rd_sr (
                .clk        (clk),
                .reset_n    (reset_n),
                .ctrl_code  (rd_mode[k]),
                .data_in    (input_data_b[k]),
                .data_write ('0),
                .data_read  (lane_data[k]),
                .data_out   ()
            );
        end

        // One write register per result row
        for (i = 0; i < `SA_W_ROWS; i++) begin : g_wr
            shift_reg #(
                .WIDTH  ($bits(acc_t)),
                .LENGTH (`SA_A_COLS)
            ) wr_sr (
                .clk        (clk),
                .reset_n    (reset_n),
                .ctrl_code  (wr_mode[i]),
                .data_in    ('0),
                .data_write (core.p_lanes[i]),
                .data_read  (),
                .data_out   (result_w[i])
            );
        end
    endgenerate

endmodule

/* sys_array_pe.sv */
`timescale 1ns/1ps

module sys_array_pe
    import sa_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  weight_load,
    input  elem_t weight_in,
    input  elem_t act_in,    // From the left
    input  acc_t  sum_in,    // From above
    output elem_t act_out,   // To the right
    output acc_t  sum_out    // Downward
);

    elem_t weight;   // Stationary weight
    acc_t  product;

    // 8x8 product fits acc_t exactly
    assign product = acc_t'(weight) * acc_t'(act_in);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            weight  <= '0;
            act_out <= '0;
            sum_out <= '0;
        end else begin
            if (weight_load)
                weight <= weight_in;
            act_out <= act_in;
            sum_out <= sum_in + product;  // Wraps at acc_t width
        end
    end

endmodule

/* sys_array_top.sv */
`timescale 1ns/1ps
`include "sa_settings.svh"

module sys_array_top
    import sa_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  load_params,                                   // Weight load strobe
    input  logic  start_comp,                                    // Start strobe
    input  elem_t [0:`SA_W_ROWS-1][0:`SA_W_COLS-1] input_data_w,  // Weight matrix W
    input  elem_t [0:`SA_A_ROWS-1][0:`SA_A_COLS-1] input_data_b,  // Data matrix B
    output logic  ready,                                         // Result valid level
    output acc_t  [0:`SA_W_ROWS-1][0:`SA_A_COLS-1] out_data       // C = W x B
);

    sa_core_if core ();

    // Sequencer with the read and write shift registers
    sys_array_fetcher fetcher0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .load_params  (load_params),
        .start_comp   (start_comp),
        .input_data_w (input_data_w),
        .input_data_b (input_data_b),
        .ready        (ready),
        .out_data     (out_data),
        .core         (core)
    );

    // Weight-stationary PE grid
    sys_array_basic array0 (
        .clk     (clk),
        .reset_n (reset_n),
        .core    (core)
    );

endmodule

/* tb_sys_array.sv */
`timescale 1ns/1ps
`include "sa_settings.svh"

module tb_sys_array
    import sa_pkg::*;
();

    typedef elem_t [0:`SA_W_ROWS-1][0:`SA_W_COLS-1] w_mat_t;
    typedef elem_t [0:`SA_A_ROWS-1][0:`SA_A_COLS-1] b_mat_t;
    typedef acc_t  [0:`SA_W_ROWS-1][0:`SA_A_COLS-1] c_mat_t;

    localparam int READY_TIMEOUT = 100;  // Cycles well above the fixed latency

    logic   clk;
    logic   reset_n;
    logic   load_params;
    logic   start_comp;
    w_mat_t input_data_w;
    b_mat_t input_data_b;
    logic   ready;
    c_mat_t out_data;

    int          value_errors   = 0;
    int          timeout_errors = 0;
    logic [31:0] lfsr_state     = 32'h7df9_82da;

    sys_array_top dut0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .load_params  (load_params),
        .start_comp   (start_comp),
        .input_data_w (input_data_w),
        .input_data_b (input_data_b),
        .ready        (ready),
        .out_data     (out_data)
    );

    always #20 clk = ~clk;

    // Right-shifting Galois LFSR with taps for x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    function automatic elem_t next_elem();
        elem_t v;
        v = '0;
        for (int n = 0; n < $bits(elem_t); n++) begin
            lfsr_state = lfsr_step(lfsr_state);  // One step per bit
            v = {v[$bits(elem_t)-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic random_weights(output w_mat_t w);
        for (int i = 0; i < `SA_W_ROWS; i++)
            for (int k = 0; k < `SA_W_COLS; k++)
                w[i][k] = next_elem();
    endtask

    task automatic random_data(output b_mat_t b);
        for (int k = 0; k < `SA_A_ROWS; k++)
            for (int j = 0; j < `SA_A_COLS; j++)
                b[k][j] = next_elem();
    endtask

    // C[i][j] is the sum over k of W[i][k] * B[k][j] in 16 bits
    task automatic compute_reference(input w_mat_t w, input b_mat_t b, output c_mat_t c);
        int sum;
        for (int i = 0; i < `SA_W_ROWS; i++) begin
            for (int j = 0; j < `SA_A_COLS; j++) begin
                sum = 0;
                for (int k = 0; k < `SA_W_COLS; k++)
                    sum += int'(w[i][k]) * int'(b[k][j]);
                c[i][j] = acc_t'(sum);
            end
        end
    endtask

    task automatic check_sum(input string name, input acc_t got, input acc_t expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic check_result(input c_mat_t expected);
        for (int i = 0; i < `SA_W_ROWS; i++)
            for (int j = 0; j < `SA_A_COLS; j++)
                check_sum($sformatf("out_data[%0d][%0d]", i, j), out_data[i][j], expected[i][j]);
    endtask

    task automatic load_weights(input w_mat_t w);
        @(posedge clk);
        input_data_w <= w;
        load_params  <= 1'b1;
        @(posedge clk);
        load_params  <= 1'b0;
    endtask

    // Returns right after the edge that samples start_comp
    task automatic start_run(input b_mat_t b);
        @(posedge clk);
        input_data_b <= b;
        start_comp   <= 1'b1;
        @(posedge clk);
        start_comp   <= 1'b0;
    endtask

    task automatic wait_for_ready();
        int n;
        n = 0;
        do begin
            @(negedge clk);  // Outputs settled here
            n++;
        end while (!ready && n < READY_TIMEOUT);
        if (!ready) begin
            $display("Timed out waiting for ready after %0d cycles", n);
            timeout_errors++;
        end
    endtask

    task automatic run_and_check(input b_mat_t b, input c_mat_t expected);
        start_run(b);
        wait_for_ready();
        check_result(expected);
    endtask

    task automatic reset_values();
        @(negedge clk);
        check_level("ready", ready, 1'b0);
        check_result('0);
    endtask

    task automatic identity_weights();
        w_mat_t w;
        b_mat_t b;
        c_mat_t expected;
        w = '0;
        for (int i = 0; i < `SA_W_ROWS; i++)
            w[i][i] = elem_t'(1);
        random_data(b);
        // Result is the first rows of B
        for (int i = 0; i < `SA_W_ROWS; i++)
            for (int j = 0; j < `SA_A_COLS; j++)
                expected[i][j] = acc_t'(b[i][j]);
        load_weights(w);
        run_and_check(b, expected);
    endtask

    task automatic random_matrices();
        w_mat_t w;
        b_mat_t b;
        c_mat_t expected;
        for (int r = 0; r < 8; r++) begin
            random_weights(w);
            random_data(b);
            compute_reference(w, b, expected);
            load_weights(w);
            run_and_check(b, expected);
        end
        // Every sum wraps with all inputs at maximum
        w = '1;
        b = '1;
        compute_reference(w, b, expected);
        load_weights(w);
        run_and_check(b, expected);
    endtask

    task automatic weight_reuse();
        w_mat_t w1, w2;
        b_mat_t b1, b2;
        c_mat_t expected;
        random_weights(w1);
        random_weights(w2);
        random_data(b1);
        random_data(b2);
        load_weights(w1);
        compute_reference(w1, b1, expected);
        run_and_check(b1, expected);
        @(posedge clk);
        input_data_w <= w2;  // PEs keep w1 without a strobe
        compute_reference(w1, b2, expected);
        run_and_check(b2, expected);
        load_weights(w2);
        compute_reference(w2, b2, expected);
        run_and_check(b2, expected);
    endtask

    task automatic busy_start();
        w_mat_t w, w_other;
        b_mat_t b1, b2;
        c_mat_t expected;
        random_weights(w);
        random_weights(w_other);
        random_data(b1);
        random_data(b2);
        compute_reference(w, b1, expected);
        load_weights(w);
        start_run(b1);
        repeat (3) @(posedge clk);
        input_data_b <= b2;  // Second start and a weight load in mid-run
        input_data_w <= w_other;
        start_comp   <= 1'b1;
        load_params  <= 1'b1;
        @(posedge clk);
        start_comp   <= 1'b0;
        load_params  <= 1'b0;
        wait_for_ready();
        check_result(expected);
        // Level holds with no new start
        repeat (6) begin
            @(negedge clk);
            check_level("ready", ready, 1'b1);
        end
        start_run(b2);
        @(negedge clk);
        check_level("ready", ready, 1'b0);
        compute_reference(w, b2, expected);  // PEs still hold w
        wait_for_ready();
        check_result(expected);
    endtask

    initial begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        load_params  = 1'b0;
        start_comp   = 1'b0;
        input_data_w = '0;
        input_data_b = '0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        reset_values();
        identity_weights();
        random_matrices();
        weight_reuse();
        busy_start();

        $display("Error counts: %0d value mismatches, %0d timeouts",
                 value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
